//--- logic/ooo_pkg.sv
package ooo_pkg;

    // ************************************************************************
    // Machine sizes
    // ************************************************************************
    localparam int unsigned XLEN      = 32;
    localparam int unsigned PHYS_REGS = 64;
    localparam int unsigned ROB_DEPTH = 16;
    localparam int unsigned WB_WIDTH  = 4;
    localparam int unsigned CDB_WIDTH = WB_WIDTH;
    localparam int unsigned ARCH_REGS = 32;
    localparam int unsigned ROB_CNT_W = $clog2(ROB_DEPTH + 1);

    typedef logic [XLEN-1:0]              xlen_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_tag_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    // Occupancy needs one more bit than an index
    typedef logic [ROB_CNT_W-1:0]         rob_cnt_t;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_BEQ = 3'd4
    } alu_op_t;

    // ************************************************************************
    // Pipeline payloads
    // ************************************************************************
    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        xlen_t     src_a;
        xlen_t     src_b;
        arch_reg_t dest_arch;
        phys_tag_t dest_prf;
        rob_idx_t  rob_idx;
    } issue_req_t;

    typedef struct packed {
        logic      valid;
        xlen_t     value;
        arch_reg_t dest_arch;
        phys_tag_t dest_prf;
        rob_idx_t  rob_idx;
        logic      exception;
        logic      mispred;
    } fu_result_t;

    typedef struct packed {
        logic      wr_en;
        phys_tag_t waddr;
        xlen_t     wdata;
    } prf_write_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        logic     exception;
        logic     mispred;
        xlen_t    value;
    } wb_entry_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t dest_arch;
        phys_tag_t phys_tag;
        xlen_t     value;
    } cdb_entry_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        logic     exception;
        logic     mispred;
        xlen_t    value;
    } retire_t;

endpackage

//--- logic/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import ooo_pkg::*; (
    input  logic                        clock,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  issue_req_t [WB_WIDTH-1:0]   issue_i,
    output fu_result_t [WB_WIDTH-1:0]   result_o
);

    fu_result_t [WB_WIDTH-1:0] lane_res;
    fu_result_t [WB_WIDTH-1:0] res_q;

    // One ALU lane, tags pass straight through
    function automatic fu_result_t alu_lane(issue_req_t req);
        fu_result_t res;
        xlen_t      sum;
        xlen_t      diff;
        logic       equal;
        sum   = req.src_a + req.src_b;
        diff  = req.src_a - req.src_b;
        equal = (req.src_a == req.src_b);
        res           = '0;
        res.valid     = req.valid;
        res.dest_arch = req.dest_arch;
        res.dest_prf  = req.dest_prf;
        res.rob_idx   = req.rob_idx;
        case (req.op)
            OP_ADD: begin
                res.value     = sum;
                res.exception = (req.src_a[XLEN-1] == req.src_b[XLEN-1]) &&
                                (sum[XLEN-1] != req.src_a[XLEN-1]);
            end
            OP_SUB: begin
                res.value     = diff;
                res.exception = (req.src_a[XLEN-1] != req.src_b[XLEN-1]) &&
                                (diff[XLEN-1] != req.src_a[XLEN-1]);
            end
            OP_AND: begin
                res.value = req.src_a & req.src_b;
            end
            OP_XOR: begin
                res.value = req.src_a ^ req.src_b;
            end
            OP_BEQ: begin
                // Predicted not-taken so a taken branch is a mispredict
                res.value   = xlen_t'(equal);
                res.mispred = equal;
            end
            default: begin
                res.value = '0;
            end
        endcase
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < WB_WIDTH; i++) begin
            lane_res[i] = alu_lane(issue_i[i]);
        end
    end

    // Payload is captured every cycle, only the valids see reset and flush
    always_ff @(posedge clock) begin
        for (int i = 0; i < WB_WIDTH; i++) begin
            res_q[i] <= lane_res[i];
            if (!rst_n_i || flush_i) begin
                res_q[i].valid <= 1'b0;
            end
        end
    end

    assign result_o = res_q;

endmodule

//--- logic/complete_stage.sv
`timescale 1ns/1ns

module complete_stage import ooo_pkg::*; (
    input  logic                         clock,
    input  logic                         rst_n_i,

    input  fu_result_t [WB_WIDTH-1:0]    fu_result_i,

    output prf_write_t [WB_WIDTH-1:0]    prf_wr_o,
    output wb_entry_t  [WB_WIDTH-1:0]    wb_o,
    output cdb_entry_t [CDB_WIDTH-1:0]   cdb_o
);

    // ************************************************************************
    // Result fan-out
    // ************************************************************************
    always_comb begin
        prf_wr_o = '0;
        wb_o     = '0;
        cdb_o    = '0;

        for (int i = 0; i < WB_WIDTH; i++) begin
            if (fu_result_i[i].valid) begin
                // Register file write port
                prf_wr_o[i].wr_en = 1'b1;
                prf_wr_o[i].waddr = fu_result_i[i].dest_prf;
                prf_wr_o[i].wdata = fu_result_i[i].value;

                // ROB completion
                wb_o[i].valid     = 1'b1;
                wb_o[i].rob_idx   = fu_result_i[i].rob_idx;
                wb_o[i].exception = fu_result_i[i].exception;
                wb_o[i].mispred   = fu_result_i[i].mispred;
                wb_o[i].value     = fu_result_i[i].value;

                // Broadcast to waiting consumers
                cdb_o[i].valid     = 1'b1;
                cdb_o[i].dest_arch = fu_result_i[i].dest_arch;
                cdb_o[i].phys_tag  = fu_result_i[i].dest_prf;
                cdb_o[i].value     = fu_result_i[i].value;
            end
        end
    end

endmodule

//--- logic/phys_regfile.sv
`timescale 1ns/1ns

module phys_regfile import ooo_pkg::*; (
    input  logic                       clock,
    input  logic                       rst_n_i,

    input  prf_write_t [WB_WIDTH-1:0]  wr_i,

    input  phys_tag_t                  rd_addr_i,
    output xlen_t                      rd_data_o
);

    xlen_t regs_q [PHYS_REGS];

    // ************************************************************************
    // Write ports
    // ************************************************************************
    // Later lanes are applied last so the higher lane wins a collision
    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            for (int r = 0; r < PHYS_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int i = 0; i < WB_WIDTH; i++) begin
                if (wr_i[i].wr_en) begin
                    regs_q[wr_i[i].waddr] <= wr_i[i].wdata;
                end
            end
        end
    end

    // Read port
    assign rd_data_o = regs_q[rd_addr_i];

endmodule

//--- logic/reorder_buffer.sv
`timescale 1ns/1ns

module reorder_buffer import ooo_pkg::*; (
    input  logic                       clock,
    input  logic                       rst_n_i,

    // Allocation
    input  logic                       alloc_i,
    output rob_idx_t                   alloc_idx_o,
    output logic                       full_o,

    // Writeback
    input  wb_entry_t [WB_WIDTH-1:0]   wb_i,

    // Retirement
    output retire_t                    retire_o,
    output logic                       flush_o
);

    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    rob_cnt_t             count_q;
    logic [ROB_DEPTH-1:0] done_q;

    xlen_t                value_q   [ROB_DEPTH];
    logic                 exc_q     [ROB_DEPTH];
    logic                 mispred_q [ROB_DEPTH];

    retire_t              retire_q;
    logic                 alloc_fire;
    logic                 retire_fire;

    assign full_o      = (count_q == rob_cnt_t'(ROB_DEPTH));
    assign alloc_idx_o = tail_q;
    assign alloc_fire  = alloc_i && !full_o;

    // Nothing retires while the flush is in progress
    assign retire_fire = !flush_o && (count_q != '0) && done_q[head_q];

    // ************************************************************************
    // Pointers
    // ************************************************************************
    always_ff @(posedge clock) begin
        if (!rst_n_i || flush_o) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_fire) begin
                tail_q <= tail_q + rob_idx_t'(1);
            end
            if (retire_fire) begin
                head_q <= head_q + rob_idx_t'(1);
            end
            count_q <= count_q + rob_cnt_t'(alloc_fire) - rob_cnt_t'(retire_fire);
        end
    end

    // ************************************************************************
    // Completion table
    // ************************************************************************
    always_ff @(posedge clock) begin
        if (!rst_n_i || flush_o) begin
            done_q <= '0;
        end else begin
            if (alloc_fire) begin
                done_q[tail_q] <= 1'b0;
            end
            for (int i = 0; i < WB_WIDTH; i++) begin
                if (wb_i[i].valid) begin
                    done_q[wb_i[i].rob_idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < WB_WIDTH; i++) begin
            if (wb_i[i].valid) begin
                value_q[wb_i[i].rob_idx]   <= wb_i[i].value;
                exc_q[wb_i[i].rob_idx]     <= wb_i[i].exception;
                mispred_q[wb_i[i].rob_idx] <= wb_i[i].mispred;
            end
        end
    end

    // ************************************************************************
    // In-order retirement
    // ************************************************************************
    always_ff @(posedge clock) begin
        retire_q.rob_idx   <= head_q;
        retire_q.exception <= exc_q[head_q];
        retire_q.mispred   <= mispred_q[head_q];
        retire_q.value     <= value_q[head_q];
        if (!rst_n_i || flush_o) begin
            retire_q.valid <= 1'b0;
        end else begin
            retire_q.valid <= retire_fire;
        end
    end

    assign retire_o = retire_q;

    // Flush lasts exactly the cycle of the faulting retirement
    assign flush_o = retire_q.valid && (retire_q.exception || retire_q.mispred);

endmodule

//--- logic/wb_cluster.sv
`timescale 1ns/1ns

module wb_cluster import ooo_pkg::*; (
    input  logic                         clock,
    input  logic                         rst_n_i,

    // Issue side
    input  issue_req_t [WB_WIDTH-1:0]    issue_i,

    // ROB allocation
    input  logic                         alloc_i,
    output rob_idx_t                     alloc_idx_o,
    output logic                         full_o,

    // Broadcast
    output cdb_entry_t [CDB_WIDTH-1:0]   cdb_o,

    // Register file read
    input  phys_tag_t                    rd_addr_i,
    output xlen_t                        rd_data_o,

    // Retirement
    output retire_t                      retire_o,
    output logic                         flush_o
);

    fu_result_t [WB_WIDTH-1:0] fu_result;
    prf_write_t [WB_WIDTH-1:0] prf_wr;
    wb_entry_t  [WB_WIDTH-1:0] rob_wb;

    execute_stage i_execute_stage (
        .clock    (clock),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_o),
        .issue_i  (issue_i),
        .result_o (fu_result)
    );

    complete_stage i_complete_stage (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .fu_result_i (fu_result),
        .prf_wr_o    (prf_wr),
        .wb_o        (rob_wb),
        .cdb_o       (cdb_o)
    );

    phys_regfile i_phys_regfile (
        .clock     (clock),
        .rst_n_i   (rst_n_i),
        .wr_i      (prf_wr),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o)
    );

    reorder_buffer i_reorder_buffer (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .alloc_i     (alloc_i),
        .alloc_idx_o (alloc_idx_o),
        .full_o      (full_o),
        .wb_i        (rob_wb),
        .retire_o    (retire_o),
        .flush_o     (flush_o)
    );

endmodule

//--- verification/wb_cluster_tb.sv
`timescale 1ns/1ns

module wb_cluster_tb import ooo_pkg::*; ();

    logic                       clock;
    logic                       rst_n_i;
    issue_req_t [WB_WIDTH-1:0]  issue_i;
    logic                       alloc_i;
    rob_idx_t                   alloc_idx_o;
    logic                       full_o;
    cdb_entry_t [CDB_WIDTH-1:0] cdb_o;
    phys_tag_t                  rd_addr_i;
    xlen_t                      rd_data_o;
    retire_t                    retire_o;
    logic                       flush_o;

    int                         seed;
    int                         errors;
    int                         prop_errors;
    int                         start_errs;
    int                         tests_run;
    int                         tests_failed;
    string                      cur_test;
    issue_req_t [WB_WIDTH-1:0]  lanes;
    rob_idx_t                   first;
    rob_idx_t                   idx_before;
    xlen_t                      opnd;
    // Model state holds {exception, mispred, value} per ROB slot
    logic [33:0]                exp_res [ROB_DEPTH];
    xlen_t                      exp_reg [PHYS_REGS];

    wb_cluster i_wb_cluster (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .issue_i     (issue_i),
        .alloc_i     (alloc_i),
        .alloc_idx_o (alloc_idx_o),
        .full_o      (full_o),
        .cdb_o       (cdb_o),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o),
        .retire_o    (retire_o),
        .flush_o     (flush_o)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // One cycle of flush leaves the ROB empty with nothing retiring
    flush_restarts_rob: assert property (@(posedge clock) disable iff (!rst_n_i)
        flush_o |=> (!flush_o && !retire_o.valid && alloc_idx_o == '0))
        else begin
            $display("ROB did not restart empty after the flush in %s", cur_test);
            prop_errors++;
        end

    // ************************************************************************
    // Reference model
    // ************************************************************************
    function automatic logic [33:0] ref_alu(alu_op_t op, xlen_t a, xlen_t b);
        logic [32:0] wide;
        logic [33:0] res;
        res = '0;
        case (op)
            OP_ADD: begin
                wide = {a[31], a} + {b[31], b};
                res  = {(wide[32] != wide[31]), 1'b0, wide[31:0]};
            end
            OP_SUB: begin
                wide = {a[31], a} - {b[31], b};
                res  = {(wide[32] != wide[31]), 1'b0, wide[31:0]};
            end
            OP_AND:  res = {2'b00, a & b};
            OP_XOR:  res = {2'b00, a ^ b};
            OP_BEQ:  res = {1'b0, (a == b), 31'd0, (a == b)};
            default: res = '0;
        endcase
        return res;
    endfunction

    // Operands below 2**30 never overflow
    function automatic xlen_t next_operand();
        xlen_t r;
        r = $random(seed);
        return r & 32'h3fff_ffff;
    endfunction

    function automatic alu_op_t next_op();
        logic [31:0] r;
        r = $random(seed);
        return alu_op_t'({1'b0, r[1:0]});
    endfunction

    function automatic issue_req_t make_req(alu_op_t op, xlen_t a, xlen_t b,
                                            phys_tag_t tag, rob_idx_t idx);
        issue_req_t r;
        r.valid     = 1'b1;
        r.op        = op;
        r.src_a     = a;
        r.src_b     = b;
        r.dest_arch = ~tag[4:0];
        r.dest_prf  = tag;
        r.rob_idx   = idx;
        return r;
    endfunction

    // ************************************************************************
    // Stimulus and check tasks
    // ************************************************************************
    task automatic check_val(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     cur_test, field, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        start_errs = errors + prop_errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors + prop_errors == start_errs) begin
            $display("[PASS] %s", cur_test);
        end else begin
            tests_failed++;
            $display("[FAIL] %s", cur_test);
        end
    endtask

    // One allocation per edge while the ROB has room
    task automatic alloc_block(input int n, output rob_idx_t base);
        @(negedge clock);
        base    = alloc_idx_o;
        alloc_i = 1'b1;
        repeat (n) @(negedge clock);
        alloc_i = 1'b0;
    endtask

    // Called on a falling edge and returns once the results sit on the CDB
    task automatic send(input issue_req_t [WB_WIDTH-1:0] reqs);
        issue_i = reqs;
        for (int i = 0; i < WB_WIDTH; i++) begin
            if (reqs[i].valid) begin
                exp_res[reqs[i].rob_idx]  = ref_alu(reqs[i].op, reqs[i].src_a, reqs[i].src_b);
                exp_reg[reqs[i].dest_prf] = exp_res[reqs[i].rob_idx][31:0];
            end
        end
        @(negedge clock);
        issue_i = '0;
    endtask

    task automatic read_check(input phys_tag_t tag, input xlen_t exp);
        @(negedge clock);
        rd_addr_i = tag;
        #1;
        check_val($sformatf("register %0d", tag), exp, rd_data_o);
    endtask

    task automatic wait_retire(input rob_idx_t idx, input logic exp_flush);
        logic seen;
        seen = 1'b0;
        for (int c = 0; c < 40 && !seen; c++) begin
            @(negedge clock);
            seen = retire_o.valid;
        end
        if (!seen) begin
            $display("Timeout in %s: ROB entry %0d never retired", cur_test, idx);
            errors++;
        end else begin
            check_val("retire index", 32'(idx), 32'(retire_o.rob_idx));
            check_val("retire value", exp_res[idx][31:0], retire_o.value);
            check_val("retire exception", 32'(exp_res[idx][33]), 32'(retire_o.exception));
            check_val("retire mispred", 32'(exp_res[idx][32]), 32'(retire_o.mispred));
            check_val("flush", 32'(exp_flush), 32'(flush_o));
        end
    endtask

    // Older faulting op completes after two younger ones
    task automatic fault_case(input alu_op_t op, input xlen_t a, input xlen_t b,
                              input int tag_base);
        rob_idx_t base;
        alloc_block(3, base);
        lanes    = '0;
        lanes[0] = make_req(OP_XOR, next_operand(), next_operand(),
                            phys_tag_t'(tag_base + 1), base + rob_idx_t'(1));
        lanes[1] = make_req(OP_AND, next_operand(), next_operand(),
                            phys_tag_t'(tag_base + 2), base + rob_idx_t'(2));
        send(lanes);
        lanes    = '0;
        lanes[0] = make_req(op, a, b, phys_tag_t'(tag_base), base);
        send(lanes);
        wait_retire(base, 1'b1);
        for (int c = 0; c < 8; c++) begin
            @(negedge clock);
            assert (!retire_o.valid) else begin
                $display("Younger entry %0d retired after the flush in %s",
                         retire_o.rob_idx, cur_test);
                errors++;
            end
        end
        check_val("alloc index after flush", 32'd0, 32'(alloc_idx_o));
    endtask

    // ************************************************************************
    // Test sequence
    // ************************************************************************
    initial begin
        seed         = 32'h46ec28ae;
        errors       = 0;
        prop_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n_i      = 1'b0;
        issue_i      = '0;
        alloc_i      = 1'b0;
        rd_addr_i    = '0;
        repeat (16) @(negedge clock);
        rst_n_i = 1'b1;

        start_test("reset_state");
        check_val("retire valid", 32'd0, 32'(retire_o.valid));
        check_val("flush", 32'd0, 32'(flush_o));
        check_val("full", 32'd0, 32'(full_o));
        for (int i = 0; i < CDB_WIDTH; i++) begin
            check_val("cdb valid", 32'd0, 32'(cdb_o[i].valid));
        end
        for (int t = 0; t < PHYS_REGS; t++) begin
            read_check(phys_tag_t'(t), 32'd0);
        end
        end_test();

        start_test("cdb_broadcast");
        alloc_block(4, first);
        for (int i = 0; i < WB_WIDTH; i++) begin
            lanes[i] = make_req(next_op(), next_operand(), next_operand(),
                                phys_tag_t'(20 + i), first + rob_idx_t'(i));
        end
        send(lanes);
        for (int i = 0; i < CDB_WIDTH; i++) begin
            check_val("cdb valid", 32'd1, 32'(cdb_o[i].valid));
            check_val("cdb tag", 32'(lanes[i].dest_prf), 32'(cdb_o[i].phys_tag));
            check_val("cdb arch", 32'(lanes[i].dest_arch), 32'(cdb_o[i].dest_arch));
            check_val("cdb value", exp_reg[lanes[i].dest_prf], cdb_o[i].value);
        end
        for (int i = 0; i < WB_WIDTH; i++) begin
            wait_retire(first + rob_idx_t'(i), 1'b0);
        end
        end_test();

        start_test("register_file");
        for (int i = 0; i < WB_WIDTH; i++) begin
            read_check(lanes[i].dest_prf, exp_reg[lanes[i].dest_prf]);
        end
        end_test();

        start_test("in_order_retire");
        alloc_block(8, first);
        for (int k = 7; k >= 0; k--) begin
            lanes    = '0;
            lanes[0] = make_req(next_op(), next_operand(), next_operand(),
                                phys_tag_t'(30 + k), first + rob_idx_t'(k));
            send(lanes);
        end
        for (int k = 0; k < 8; k++) begin
            wait_retire(first + rob_idx_t'(k), 1'b0);
        end
        end_test();

        start_test("flush_on_fault");
        opnd = next_operand() | 32'h1;
        fault_case(OP_ADD, 32'h7fff_ffff, opnd, 40);
        opnd = next_operand();
        fault_case(OP_BEQ, opnd, opnd, 50);
        end_test();

        start_test("full_flag");
        alloc_block(ROB_DEPTH, first);
        check_val("full after 16 allocations", 32'd1, 32'(full_o));
        idx_before = alloc_idx_o;
        alloc_i    = 1'b1;
        @(negedge clock);
        alloc_i = 1'b0;
        check_val("alloc index when full", 32'(idx_before), 32'(alloc_idx_o));
        check_val("full after ignored allocation", 32'd1, 32'(full_o));
        lanes    = '0;
        lanes[0] = make_req(OP_XOR, next_operand(), next_operand(), phys_tag_t'(60), first);
        send(lanes);
        wait_retire(first, 1'b0);
        check_val("full after one retirement", 32'd0, 32'(full_o));
        end_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors + prop_errors);
        if (errors + prop_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- wb_cluster.f
logic/ooo_pkg.sv
logic/execute_stage.sv
logic/complete_stage.sv
logic/phys_regfile.sv
logic/reorder_buffer.sv
logic/wb_cluster.sv
verification/wb_cluster_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = wb_cluster_tb
FILELIST  = wb_cluster.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
